/* hw/div_defs.svh */
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

`define DIV_XLEN      32  // Operand and result width.
`define DIV_TAG_W     7   // Physical register tag width.

// One quotient bit per stage.
`define DIV_STAGES    32

`define DIV_CPL_DEPTH 4   // Also the credit count after reset.
`define DIV_CPL_PTR_W 2

`endif

/* hw/div_pkg.sv */
`include "div_defs.svh"

package div_pkg;

    typedef logic [`DIV_XLEN-1:0]    xlen_t;    // Operand, quotient or remainder.
    typedef logic [`DIV_TAG_W-1:0]   tag_t;     // Physical destination register.
    typedef logic [31:0]             pc_t;

    // Partial remainder handed from one step to the next.
    typedef logic [`DIV_XLEN-1:0]    rem_t;

    typedef logic [`DIV_CPL_PTR_W:0] credit_t;  // Counts 0 to DIV_CPL_DEPTH.

endpackage

/* hw/div_issue.sv */
`timescale 1ns/10ps
`include "div_defs.svh"

module div_issue (
    input  logic           clk,
    input  logic           reset,
    input  logic           issue_valid,
    input  div_pkg::xlen_t issue_a,
    input  div_pkg::xlen_t issue_b,
    input  div_pkg::tag_t  issue_tag,
    input  div_pkg::pc_t   issue_pc,
    input  logic           issue_rem,
    input  logic           cpl_pop,
    output logic           issue_ready,
    output logic           s0_valid,
    output div_pkg::rem_t  s0_rem,
    output div_pkg::xlen_t s0_quo,
    output div_pkg::xlen_t s0_div,
    output div_pkg::tag_t  s0_tag,
    output div_pkg::pc_t   s0_pc,
    output logic           s0_sel_rem
);
    import div_pkg::*;

    credit_t credits;
    logic    accept;

    assign issue_ready = (credits != '0);  // A queue slot is reserved per issue.
    assign accept      = issue_valid && issue_ready;

    // Simultaneous issue and pop leave the count unchanged.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits <= credit_t'(`DIV_CPL_DEPTH);
        end else if (accept && !cpl_pop) begin
            credits <= credits - 1'b1;
        end else if (cpl_pop && !accept) begin
            credits <= credits + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s0_valid <= 1'b0;
        end else begin
            s0_valid <= accept;  // Bubble when nothing enters.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s0_rem     <= '0;
            s0_quo     <= issue_a;  // Dividend bits shift out of the top.
            s0_div     <= issue_b;
            s0_tag     <= issue_tag;
            s0_pc      <= issue_pc;
            s0_sel_rem <= issue_rem;
        end
    end

endmodule

/* hw/div_stage.sv */
`timescale 1ns/10ps
`include "div_defs.svh"

module div_stage (
    input  logic           clk,
    input  logic           reset,
    input  logic           in_valid,
    input  div_pkg::rem_t  in_rem,
    input  div_pkg::xlen_t in_quo,
    input  div_pkg::xlen_t in_div,
    input  div_pkg::tag_t  in_tag,
    input  div_pkg::pc_t   in_pc,
    input  logic           in_sel_rem,
    output logic           out_valid,
    output div_pkg::rem_t  out_rem,
    output div_pkg::xlen_t out_quo,
    output div_pkg::xlen_t out_div,
    output div_pkg::tag_t  out_tag,
    output div_pkg::pc_t   out_pc,
    output logic           out_sel_rem
);
    import div_pkg::*;

    logic [`DIV_XLEN:0] trial;  // Shifted remainder needs one extra bit.
    logic [`DIV_XLEN:0] diff;
    logic               fits;
    rem_t               next_rem;

    always_comb begin
        trial    = {in_rem, in_quo[`DIV_XLEN-1]};
        diff     = trial - {1'b0, in_div};
        fits     = (trial >= {1'b0, in_div});  // Always true for a zero divisor.
        next_rem = fits ? diff[`DIV_XLEN-1:0] : trial[`DIV_XLEN-1:0];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_rem     <= next_rem;
        out_quo     <= {in_quo[`DIV_XLEN-2:0], fits};  // New quotient bit enters at the bottom.
        out_div     <= in_div;
        out_tag     <= in_tag;
        out_pc      <= in_pc;
        out_sel_rem <= in_sel_rem;
    end

endmodule

/* hw/div_array.sv */
`timescale 1ns/10ps
`include "div_defs.svh"

module div_array (
    input  logic           clk,
    input  logic           reset,
    input  logic           s0_valid,
    input  div_pkg::rem_t  s0_rem,
    input  div_pkg::xlen_t s0_quo,
    input  div_pkg::xlen_t s0_div,
    input  div_pkg::tag_t  s0_tag,
    input  div_pkg::pc_t   s0_pc,
    input  logic           s0_sel_rem,
    output logic           res_valid,
    output div_pkg::xlen_t res_data,
    output div_pkg::tag_t  res_tag,
    output div_pkg::pc_t   res_pc
);
    import div_pkg::*;

    // Index 0 is slot zero, index DIV_STAGES the last step's output.
    logic  valid_chain [0:`DIV_STAGES];
    rem_t  rem_chain   [0:`DIV_STAGES];
    xlen_t quo_chain   [0:`DIV_STAGES];
    xlen_t div_chain   [0:`DIV_STAGES];
    tag_t  tag_chain   [0:`DIV_STAGES];
    pc_t   pc_chain    [0:`DIV_STAGES];
    logic  sel_chain   [0:`DIV_STAGES];

    assign valid_chain[0] = s0_valid;
    assign rem_chain[0]   = s0_rem;
    assign quo_chain[0]   = s0_quo;
    assign div_chain[0]   = s0_div;
    assign tag_chain[0]   = s0_tag;
    assign pc_chain[0]    = s0_pc;
    assign sel_chain[0]   = s0_sel_rem;

    genvar i;
    generate
        for (i = 0; i < `DIV_STAGES; i = i + 1) begin : g_stage
            div_stage stage_inst (
                .clk         (clk),
                .reset       (reset),
                .in_valid    (valid_chain[i]),
                .in_rem      (rem_chain[i]),
                .in_quo      (quo_chain[i]),
                .in_div      (div_chain[i]),
                .in_tag      (tag_chain[i]),
                .in_pc       (pc_chain[i]),
                .in_sel_rem  (sel_chain[i]),
                .out_valid   (valid_chain[i+1]),
                .out_rem     (rem_chain[i+1]),
                .out_quo     (quo_chain[i+1]),
                .out_div     (div_chain[i+1]),
                .out_tag     (tag_chain[i+1]),
                .out_pc      (pc_chain[i+1]),
                .out_sel_rem (sel_chain[i+1])
            );
        end
    endgenerate

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= valid_chain[`DIV_STAGES];
        end
    end

    always_ff @(posedge clk) begin
        res_data <= sel_chain[`DIV_STAGES] ? rem_chain[`DIV_STAGES] : quo_chain[`DIV_STAGES];
        res_tag  <= tag_chain[`DIV_STAGES];
        res_pc   <= pc_chain[`DIV_STAGES];
    end

endmodule

/* hw/div_cpl_fifo.sv */
`timescale 1ns/10ps
`include "div_defs.svh"

module div_cpl_fifo (
    input  logic           clk,
    input  logic           reset,
    input  logic           res_valid,
    input  div_pkg::xlen_t res_data,
    input  div_pkg::tag_t  res_tag,
    input  div_pkg::pc_t   res_pc,
    input  logic           cpl_ready,
    output logic           cpl_valid,
    output div_pkg::xlen_t cpl_data,
    output div_pkg::tag_t  cpl_tag,
    output div_pkg::pc_t   cpl_pc,
    output logic           cpl_pop
);
    import div_pkg::*;

    xlen_t data_mem [0:`DIV_CPL_DEPTH-1];
    tag_t  tag_mem  [0:`DIV_CPL_DEPTH-1];
    pc_t   pc_mem   [0:`DIV_CPL_DEPTH-1];

    logic [`DIV_CPL_PTR_W-1:0] wr_ptr;
    logic [`DIV_CPL_PTR_W-1:0] rd_ptr;
    logic [`DIV_CPL_PTR_W:0]   count;

    assign cpl_valid = (count != '0);
    assign cpl_pop   = cpl_valid && cpl_ready;

    // Head entry goes straight to writeback.
    assign cpl_data = data_mem[rd_ptr];
    assign cpl_tag  = tag_mem[rd_ptr];
    assign cpl_pc   = pc_mem[rd_ptr];

    // Credits keep a free entry for every result still in the array.
    always_ff @(posedge clk) begin
        if (res_valid) begin
            data_mem[wr_ptr] <= res_data;
            tag_mem[wr_ptr]  <= res_tag;
            pc_mem[wr_ptr]   <= res_pc;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (res_valid) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps with the power-of-two depth.
            end
            if (cpl_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (res_valid && !cpl_pop) begin
                count <= count + 1'b1;
            end else if (cpl_pop && !res_valid) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* hw/div_unit.sv */
`timescale 1ns/10ps
`include "div_defs.svh"

module div_unit (
    input  logic           clk,
    input  logic           reset,
    input  logic           issue_valid,
    input  div_pkg::xlen_t issue_a,
    input  div_pkg::xlen_t issue_b,
    input  div_pkg::tag_t  issue_tag,
    input  div_pkg::pc_t   issue_pc,
    input  logic           issue_rem,
    input  logic           cpl_ready,
    output logic           issue_ready,
    output logic           cpl_valid,
    output div_pkg::xlen_t cpl_data,
    output div_pkg::tag_t  cpl_tag,
    output div_pkg::pc_t   cpl_pc
);
    import div_pkg::*;

    logic  s0_valid;
    rem_t  s0_rem;
    xlen_t s0_quo;
    xlen_t s0_div;
    tag_t  s0_tag;
    pc_t   s0_pc;
    logic  s0_sel_rem;

    logic  res_valid;
    xlen_t res_data;
    tag_t  res_tag;
    pc_t   res_pc;

    logic  cpl_pop;  // Returns one credit to the issue side.

    div_issue issue_inst (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_tag   (issue_tag),
        .issue_pc    (issue_pc),
        .issue_rem   (issue_rem),
        .cpl_pop     (cpl_pop),
        .issue_ready (issue_ready),
        .s0_valid    (s0_valid),
        .s0_rem      (s0_rem),
        .s0_quo      (s0_quo),
        .s0_div      (s0_div),
        .s0_tag      (s0_tag),
        .s0_pc       (s0_pc),
        .s0_sel_rem  (s0_sel_rem)
    );

    div_array array_inst (
        .clk        (clk),
        .reset      (reset),
        .s0_valid   (s0_valid),
        .s0_rem     (s0_rem),
        .s0_quo     (s0_quo),
        .s0_div     (s0_div),
        .s0_tag     (s0_tag),
        .s0_pc      (s0_pc),
        .s0_sel_rem (s0_sel_rem),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_tag    (res_tag),
        .res_pc     (res_pc)
    );

    div_cpl_fifo cpl_fifo_inst (
        .clk       (clk),
        .reset     (reset),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_tag   (res_tag),
        .res_pc    (res_pc),
        .cpl_ready (cpl_ready),
        .cpl_valid (cpl_valid),
        .cpl_data  (cpl_data),
        .cpl_tag   (cpl_tag),
        .cpl_pc    (cpl_pc),
        .cpl_pop   (cpl_pop)
    );

endmodule

/* tests/div_unit_tb.sv */
`timescale 1ns/10ps
`include "div_defs.svh"

module div_unit_tb;
    import div_pkg::*;

    localparam int NUM_BURST       = 120;
    localparam int NUM_RANDOM      = 150;
    localparam int NUM_OPS         = NUM_BURST + NUM_RANDOM + 16;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 40 + 500;
    localparam logic [31:0] SEED   = 32'd30;

    logic  clk;
    logic  reset;
    logic  issue_valid;
    logic  issue_ready;
    logic  issue_rem;
    logic  cpl_ready;
    logic  cpl_valid;
    xlen_t issue_a;
    xlen_t issue_b;
    xlen_t cpl_data;
    tag_t  issue_tag;
    tag_t  cpl_tag;
    pc_t   issue_pc;
    pc_t   cpl_pc;

    logic [31:0] lfsr;
    logic        random_ready;  // Writeback ready follows the LFSR.
    int          issued;
    int          completed;
    int          value_errors;
    int          protocol_errors;
    xlen_t       exp_data [$];
    tag_t        exp_tag  [$];
    pc_t         exp_pc   [$];

    div_unit div_unit_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = galois_step(lfsr);
        end
        return val;
    endfunction

    // Divide by zero gives all ones, or the dividend as remainder.
    function automatic xlen_t ref_result(input xlen_t a, input xlen_t b, input logic want_rem);
        if (b == '0) begin
            return want_rem ? a : '1;
        end
        return want_rem ? a % b : a / b;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        if (random_ready) begin
            cpl_ready <= (take_bits(1) != 0);
        end
    endtask

    // Returns right after the edge that accepts the operation.
    task automatic drive_op(input xlen_t a, input xlen_t b, input logic want_rem);
        issue_valid <= 1'b1;
        issue_a     <= a;
        issue_b     <= b;
        issue_rem   <= want_rem;
        issue_tag   <= tag_t'(take_bits(`DIV_TAG_W));
        issue_pc    <= issue_pc + 32'd4;
        do begin
            next_cycle();
        end while (!issue_ready);
    endtask

    task automatic idle_cycle();
        issue_valid <= 1'b0;
        next_cycle();
    endtask

    task automatic drive_random_op();
        xlen_t       a;
        xlen_t       b;
        logic [31:0] shift;
        logic        want_rem;
        a        = take_bits(32);
        b        = take_bits(32);
        shift    = take_bits(5);
        b        = b >> shift;  // Spread of divisor sizes.
        want_rem = (take_bits(1) != 0);
        if (take_bits(3) == 0) begin
            b = '0;
        end
        drive_op(a, b, want_rem);
    endtask

    task automatic wait_drained();
        while (completed != issued) begin
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            issued <= 0;
        end else if (issue_valid && issue_ready) begin
            exp_data.push_back(ref_result(issue_a, issue_b, issue_rem));
            exp_tag.push_back(issue_tag);
            exp_pc.push_back(issue_pc);
            issued <= issued + 1;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            completed <= 0;
        end else if (cpl_valid && cpl_ready) begin
            assert (exp_data.size() != 0) else begin
                protocol_errors++;
                $display("Completion at %0t with no operation outstanding", $time);
            end
            if (exp_data.size() != 0) begin
                assert (cpl_data == exp_data[0] && cpl_tag == exp_tag[0] && cpl_pc == exp_pc[0])
                else begin
                    value_errors++;
                    $display("FAILED %0t: got %h tag %h pc %h, expected %h tag %h pc %h", $time,
                             cpl_data, cpl_tag, cpl_pc, exp_data[0], exp_tag[0], exp_pc[0]);
                end
                void'(exp_data.pop_front());
                void'(exp_tag.pop_front());
                void'(exp_pc.pop_front());
            end
            completed <= completed + 1;
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            assert (issued - completed <= `DIV_CPL_DEPTH) else begin
                protocol_errors++;
                $display("Too many operations outstanding at %0t", $time);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, %0d completions missing", WATCHDOG_CYCLES,
                 issued - completed);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        lfsr            = SEED;
        random_ready    = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        reset           = 1'b1;
        issue_valid     = 1'b0;
        issue_a         = '0;
        issue_b         = '0;
        issue_tag       = '0;
        issue_pc        = 32'h0000_1000;
        issue_rem       = 1'b0;
        cpl_ready       = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (issue_ready && !cpl_valid) else begin
            protocol_errors++;
            $display("Wrong state after reset, issue_ready %b cpl_valid %b", issue_ready, cpl_valid);
        end
        @(posedge clk);
        drive_op(32'd100, 32'd7, 1'b0);
        drive_op(32'd100, 32'd7, 1'b1);
        drive_op(32'd5, 32'd9, 1'b0);
        drive_op(32'd5, 32'd9, 1'b1);
        drive_op(32'hFFFF_FFFF, 32'd1, 1'b0);
        drive_op(32'h8000_0000, 32'hFFFF_FFFF, 1'b1);
        drive_op(32'd1234, 32'd0, 1'b0);  // Zero divisor.
        drive_op(32'd1234, 32'd0, 1'b1);
        drive_op(32'd0, 32'd0, 1'b1);
        repeat (NUM_BURST) drive_random_op();
        idle_cycle();
        wait_drained();
        // Stalled writeback makes the fifth operation wait for a credit.
        cpl_ready <= 1'b0;
        repeat (`DIV_CPL_DEPTH) drive_random_op();
        fork
            drive_random_op();
            begin
                repeat (50) begin
                    @(negedge clk);
                    assert (!issue_ready) else begin
                        protocol_errors++;
                        $display("issue_ready high with no credits at %0t", $time);
                    end
                end
                assert (cpl_valid) else begin
                    protocol_errors++;
                    $display("Held results not presented at %0t", $time);
                end
                @(posedge clk);
                cpl_ready <= 1'b1;
            end
        join
        idle_cycle();
        wait_drained();
        random_ready = 1'b1;
        repeat (NUM_RANDOM) begin
            while (take_bits(2) == 0) begin
                idle_cycle();
            end
            drive_random_op();
        end
        idle_cycle();
        random_ready = 1'b0;
        cpl_ready <= 1'b1;
        wait_drained();
        $display("Errors: %0d value, %0d protocol; %0d issued, %0d completed",
                 value_errors, protocol_errors, issued, completed);
        if (value_errors == 0 && protocol_errors == 0 && issued == completed) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+hw
hw/div_pkg.sv
hw/div_issue.sv
hw/div_stage.sv
hw/div_array.sv
hw/div_cpl_fifo.sv
hw/div_unit.sv
tests/div_unit_tb.sv
